// File: verilog/cpu_pkg.sv
package cpu_pkg;

	////////////////////////////////////////
	// Bus and register geometry
	////////////////////////////////////////

	localparam int unsigned data_width = 8;
	localparam int unsigned addr_width = 16;

	// First opcode fetch after reset
	localparam logic [addr_width-1:0] reset_pc = 16'h0200;

	////////////////////////////////////////
	// Opcodes, standard 6502 encodings
	////////////////////////////////////////

	// Immediate loads
	localparam logic [data_width-1:0] op_lda_imm = 8'hA9;
	localparam logic [data_width-1:0] op_ldx_imm = 8'hA2;
	localparam logic [data_width-1:0] op_ldy_imm = 8'hA0;

	// Zero page load and stores
	localparam logic [data_width-1:0] op_lda_zp  = 8'hA5;
	localparam logic [data_width-1:0] op_sta_zp  = 8'h85;
	localparam logic [data_width-1:0] op_stx_zp  = 8'h86;
	localparam logic [data_width-1:0] op_sty_zp  = 8'h84;

	// Immediate arithmetic and logic on A
	localparam logic [data_width-1:0] op_adc_imm = 8'h69;
	localparam logic [data_width-1:0] op_sbc_imm = 8'hE9;
	localparam logic [data_width-1:0] op_and_imm = 8'h29;
	localparam logic [data_width-1:0] op_ora_imm = 8'h09;
	localparam logic [data_width-1:0] op_eor_imm = 8'h49;

	// Implied
	localparam logic [data_width-1:0] op_inx     = 8'hE8;
	localparam logic [data_width-1:0] op_iny     = 8'hC8;
	localparam logic [data_width-1:0] op_dex     = 8'hCA;
	localparam logic [data_width-1:0] op_dey     = 8'h88;
	localparam logic [data_width-1:0] op_tax     = 8'hAA;
	localparam logic [data_width-1:0] op_txa     = 8'h8A;
	localparam logic [data_width-1:0] op_clc     = 8'h18;
	localparam logic [data_width-1:0] op_sec     = 8'h38;
	localparam logic [data_width-1:0] op_nop     = 8'hEA;

	// Control flow
	localparam logic [data_width-1:0] op_jmp_abs = 8'h4C;
	localparam logic [data_width-1:0] op_beq     = 8'hF0;
	localparam logic [data_width-1:0] op_bne     = 8'hD0;

	////////////////////////////////////////
	// Datapath select codes
	////////////////////////////////////////

	typedef enum logic [2:0] {
		fn_add, fn_sub, fn_and, fn_or, fn_eor, fn_inc, fn_dec, fn_pass
	} alu_fn;

	// Write-back source into the register set
	typedef enum logic [1:0] {wb_alu, wb_mem, wb_xfer} wb_sel;

	typedef enum logic [1:0] {reg_a, reg_x, reg_y} reg_sel;

	// Bus address source
	typedef enum logic [1:0] {addr_pc, addr_zp, addr_hold} addr_sel;

endpackage

// File: verilog/alu.sv
module alu import cpu_pkg::*; (
	input  alu_fn                 func,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  logic                  carry_in,
	output logic [data_width-1:0] result,
	output logic                  carry_out,
	output logic                  zero,
	output logic                  negative
);

	logic [data_width:0] sum;
	logic [data_width:0] diff;

	// Binary add with carry, no decimal mode
	assign sum = {1'b0, a} + {1'b0, b} + {{data_width{1'b0}}, carry_in};

	// SBC is A plus inverted operand plus carry
	assign diff = {1'b0, a} + {1'b0, ~b} + {{data_width{1'b0}}, carry_in};

	always_comb begin
		// Carry untouched unless the function is ADC or SBC
		carry_out = carry_in;
		case (func)
			fn_add: begin
				result    = sum[data_width-1:0];
				carry_out = sum[data_width];
			end
			fn_sub: begin
				result    = diff[data_width-1:0];
				carry_out = diff[data_width];
			end
			fn_and: result = a & b;
			fn_or:  result = a | b;
			fn_eor: result = a ^ b;
			fn_inc: result = a + 1'b1;
			fn_dec: result = a - 1'b1;
			default: result = a;
		endcase
	end

	assign zero     = (result == '0);
	assign negative = result[data_width-1];

endmodule

// File: verilog/reg_file.sv
module reg_file import cpu_pkg::*; (
	input  logic                  phi0,
	input  logic                  rst,
	input  reg_sel                src_reg,
	input  reg_sel                dst_reg,
	input  wb_sel                 wb_source,
	input  logic                  reg_we,
	input  logic                  flag_we,
	input  logic                  carry_set,
	input  logic                  carry_clear,
	input  logic [data_width-1:0] alu_result,
	input  logic                  alu_carry,
	input  logic                  alu_zero,
	input  logic                  alu_negative,
	input  logic [data_width-1:0] mem_data,
	output logic [data_width-1:0] a_out,
	output logic [data_width-1:0] src_out,
	output logic                  carry,
	output logic                  z_flag
);

	logic [data_width-1:0] a_reg;
	logic [data_width-1:0] x_reg;
	logic [data_width-1:0] y_reg;
	logic [data_width-1:0] wb_value;
	logic                  n_flag;

	always_comb begin
		case (src_reg)
			reg_x:   src_out = x_reg;
			reg_y:   src_out = y_reg;
			default: src_out = a_reg;
		endcase
	end

	////////////////////////////////////////
	// Write-back source
	////////////////////////////////////////

	always_comb begin
		case (wb_source)
			wb_mem:  wb_value = mem_data;
			wb_xfer: wb_value = src_out;
			default: wb_value = alu_result;
		endcase
	end

	always_ff @(posedge phi0) begin
		if (rst) begin
			a_reg  <= '0;
			x_reg  <= '0;
			y_reg  <= '0;
			carry  <= 1'b0;
			z_flag <= 1'b0;
			n_flag <= 1'b0;
		end else begin
			if (reg_we) begin
				case (dst_reg)
					reg_x:   x_reg <= wb_value;
					reg_y:   y_reg <= wb_value;
					default: a_reg <= wb_value;
				endcase
			end
			// ALU ops take all three flags, loads and transfers only Z and N
			if (flag_we) begin
				if (wb_source == wb_alu) begin
					carry  <= alu_carry;
					z_flag <= alu_zero;
					n_flag <= alu_negative;
				end else begin
					z_flag <= (wb_value == '0);
					n_flag <= wb_value[data_width-1];
				end
			end
			if (carry_set) begin
				carry <= 1'b1;
			end else if (carry_clear) begin
				carry <= 1'b0;
			end
		end
	end

	assign a_out = a_reg;

endmodule

// File: verilog/fetcher.sv
module fetcher import cpu_pkg::*; (
	input  logic                  phi0,
	input  logic                  rst,
	input  logic [data_width-1:0] rdata,
	input  addr_sel               addr_select,
	input  logic                  pc_inc,
	input  logic                  load_opcode,
	input  logic                  load_operand_lo,
	input  logic                  load_operand_hi,
	input  logic                  branch_take,
	input  logic                  jump,
	output logic [addr_width-1:0] addr,
	output logic [data_width-1:0] opcode,
	output logic [addr_width-1:0] operand
);

	logic [addr_width-1:0] pc;
	logic [addr_width-1:0] addr_q;
	logic [data_width-1:0] operand_lo;
	logic [data_width-1:0] operand_hi;
	logic [addr_width-1:0] branch_offset;
	logic [addr_width-1:0] branch_target;
	logic [addr_width-1:0] jump_target;

	////////////////////////////////////////
	// Address and target arithmetic
	////////////////////////////////////////

	// Signed 8-bit offset relative to the PC already past the offset byte
	assign branch_offset = {{(addr_width - data_width){operand_lo[data_width-1]}}, operand_lo};
	assign branch_target = pc + branch_offset;

	// High byte arrives on the bus in the last JMP cycle
	assign jump_target = {rdata, operand_lo};

	always_comb begin
		case (addr_select)
			addr_zp:   addr = {{(addr_width - data_width){1'b0}}, operand_lo};
			addr_hold: addr = addr_q;
			default:   addr = pc;
		endcase
	end

	assign operand = {operand_hi, operand_lo};

	////////////////////////////////////////
	// Program counter
	////////////////////////////////////////

	always_ff @(posedge phi0) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (jump) begin
			pc <= jump_target;
		end else if (branch_take) begin
			pc <= branch_target;
		end else if (pc_inc) begin
			pc <= pc + 1'b1;
		end
	end

	// Opcode and operand capture, plus the previous bus address
	always_ff @(posedge phi0) begin
		addr_q <= addr;
		if (load_opcode) begin
			opcode <= rdata;
		end
		if (load_operand_lo) begin
			operand_lo <= rdata;
		end
		if (load_operand_hi) begin
			operand_hi <= rdata;
		end
	end

endmodule

// File: verilog/decoder.sv
module decoder import cpu_pkg::*; (
	input  logic                  phi0,
	input  logic                  rst,
	input  logic [data_width-1:0] opcode,
	input  logic [data_width-1:0] operand_now,
	input  logic                  z_flag,
	output logic                  sync,
	output logic                  mem_write,
	output addr_sel               addr_select,
	output logic                  pc_inc,
	output logic                  load_opcode,
	output logic                  load_operand_lo,
	output logic                  load_operand_hi,
	output logic                  branch_take,
	output logic                  jump,
	output alu_fn                 alu_func,
	output reg_sel                src_reg,
	output reg_sel                dst_reg,
	output wb_sel                 wb_source,
	output logic                  reg_we,
	output logic                  flag_we,
	output logic                  carry_set,
	output logic                  carry_clear
);

	typedef enum logic [1:0] {t0, t1, t2} cyc_t;

	cyc_t cyc;
	logic long_op;
	logic last_cycle;
	logic is_branch;
	logic taken;

	// Predecode of the byte on the bus during T0
	function automatic logic is_long(input logic [data_width-1:0] op);
		case (op)
			op_lda_zp, op_sta_zp, op_stx_zp, op_sty_zp,
			op_jmp_abs, op_beq, op_bne: is_long = 1'b1;
			default: is_long = 1'b0;
		endcase
	endfunction

	function automatic alu_fn imm_fn(input logic [data_width-1:0] op);
		case (op)
			op_adc_imm: imm_fn = fn_add;
			op_sbc_imm: imm_fn = fn_sub;
			op_and_imm: imm_fn = fn_and;
			op_ora_imm: imm_fn = fn_or;
			default:    imm_fn = fn_eor;
		endcase
	endfunction

	assign is_branch = (opcode == op_beq) || (opcode == op_bne);
	assign taken     = (opcode == op_beq) ? z_flag : !z_flag;

	// Held low while the core is in reset
	assign sync = (cyc == t0) && !rst;

	////////////////////////////////////////
	// Cycle sequencer
	////////////////////////////////////////

	always_ff @(posedge phi0) begin
		if (rst) begin
			cyc     <= t0;
			long_op <= 1'b0;
		end else begin
			if (cyc == t0) begin
				long_op <= is_long(operand_now);
			end
			if (last_cycle) begin
				cyc <= t0;
			end else if (cyc == t0) begin
				cyc <= t1;
			end else begin
				cyc <= t2;
			end
		end
	end

	////////////////////////////////////////
	// Per-cycle control word
	////////////////////////////////////////

	always_comb begin
		mem_write       = 1'b0;
		addr_select     = addr_pc;
		pc_inc          = 1'b0;
		load_opcode     = 1'b0;
		load_operand_lo = 1'b0;
		load_operand_hi = 1'b0;
		branch_take     = 1'b0;
		jump            = 1'b0;
		alu_func        = fn_pass;
		src_reg         = reg_a;
		dst_reg         = reg_a;
		wb_source       = wb_alu;
		reg_we          = 1'b0;
		flag_we         = 1'b0;
		carry_set       = 1'b0;
		carry_clear     = 1'b0;
		last_cycle      = 1'b0;
		case (cyc)
			t0: begin
				load_opcode = 1'b1;
				pc_inc      = 1'b1;
			end
			t1: begin
				// Unknown opcodes end here as NOPs
				last_cycle = !long_op || (is_branch && !taken);
				case (opcode)
					op_lda_imm, op_ldx_imm, op_ldy_imm: begin
						pc_inc    = 1'b1;
						wb_source = wb_mem;
						reg_we    = 1'b1;
						flag_we   = 1'b1;
						if (opcode == op_ldx_imm) begin
							dst_reg = reg_x;
						end else if (opcode == op_ldy_imm) begin
							dst_reg = reg_y;
						end
					end
					op_adc_imm, op_sbc_imm, op_and_imm, op_ora_imm, op_eor_imm: begin
						pc_inc   = 1'b1;
						alu_func = imm_fn(opcode);
						reg_we   = 1'b1;
						flag_we  = 1'b1;
					end
					op_inx, op_dex, op_iny, op_dey: begin
						alu_func = (opcode == op_inx || opcode == op_iny) ? fn_inc : fn_dec;
						src_reg  = (opcode == op_inx || opcode == op_dex) ? reg_x : reg_y;
						dst_reg  = src_reg;
						reg_we   = 1'b1;
						flag_we  = 1'b1;
					end
					op_tax, op_txa: begin
						src_reg   = (opcode == op_tax) ? reg_a : reg_x;
						dst_reg   = (opcode == op_tax) ? reg_x : reg_a;
						wb_source = wb_xfer;
						reg_we    = 1'b1;
						flag_we   = 1'b1;
					end
					op_clc: carry_clear = 1'b1;
					op_sec: carry_set = 1'b1;
					op_lda_zp, op_sta_zp, op_stx_zp, op_sty_zp,
					op_jmp_abs, op_beq, op_bne: begin
						pc_inc          = 1'b1;
						load_operand_lo = 1'b1;
					end
					default: ;
				endcase
			end
			t2: begin
				last_cycle = 1'b1;
				case (opcode)
					op_lda_zp: begin
						addr_select = addr_zp;
						wb_source   = wb_mem;
						reg_we      = 1'b1;
						flag_we     = 1'b1;
					end
					op_sta_zp, op_stx_zp, op_sty_zp: begin
						addr_select = addr_zp;
						mem_write   = 1'b1;
						if (opcode == op_stx_zp) begin
							src_reg = reg_x;
						end else if (opcode == op_sty_zp) begin
							src_reg = reg_y;
						end
					end
					op_jmp_abs: begin
						load_operand_hi = 1'b1;
						jump            = 1'b1;
					end
					// Taken branch, bus re-reads the offset address
					op_beq, op_bne: begin
						addr_select = addr_hold;
						branch_take = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// File: verilog/cpu_top.sv
module cpu_top import cpu_pkg::*; (
	input  logic                  phi0,
	input  logic                  rst,
	input  logic [data_width-1:0] rdata,
	output logic [addr_width-1:0] addr,
	output logic [data_width-1:0] wdata,
	output logic                  r_w_n,
	output logic                  sync
);

	////////////////////////////////////////
	// Internal control and datapath wires
	////////////////////////////////////////

	logic [data_width-1:0] opcode;
	addr_sel               addr_select;
	logic                  pc_inc;
	logic                  load_opcode;
	logic                  load_operand_lo;
	logic                  load_operand_hi;
	logic                  branch_take;
	logic                  jump;
	logic                  mem_write;

	alu_fn                 alu_func;
	reg_sel                src_reg;
	reg_sel                dst_reg;
	wb_sel                 wb_source;
	logic                  reg_we;
	logic                  flag_we;
	logic                  carry_set;
	logic                  carry_clear;

	logic                  carry;
	logic                  z_flag;
	logic [data_width-1:0] alu_result;
	logic                  alu_carry;
	logic                  alu_zero;
	logic                  alu_negative;

	assign r_w_n = !mem_write;

	fetcher u_fetcher (
		.phi0            (phi0),
		.rst             (rst),
		.rdata           (rdata),
		.addr_select     (addr_select),
		.pc_inc          (pc_inc),
		.load_opcode     (load_opcode),
		.load_operand_lo (load_operand_lo),
		.load_operand_hi (load_operand_hi),
		.branch_take     (branch_take),
		.jump            (jump),
		.addr            (addr),
		.opcode          (opcode),
		.operand         ()
	);

	decoder u_decoder (
		.phi0            (phi0),
		.rst             (rst),
		.opcode          (opcode),
		.operand_now     (rdata),
		.z_flag          (z_flag),
		.sync            (sync),
		.mem_write       (mem_write),
		.addr_select     (addr_select),
		.pc_inc          (pc_inc),
		.load_opcode     (load_opcode),
		.load_operand_lo (load_operand_lo),
		.load_operand_hi (load_operand_hi),
		.branch_take     (branch_take),
		.jump            (jump),
		.alu_func        (alu_func),
		.src_reg         (src_reg),
		.dst_reg         (dst_reg),
		.wb_source       (wb_source),
		.reg_we          (reg_we),
		.flag_we         (flag_we),
		.carry_set       (carry_set),
		.carry_clear     (carry_clear)
	);

	// Operand A is the selected source register, operand B the bus byte
	alu u_alu (
		.func      (alu_func),
		.a         (wdata),
		.b         (rdata),
		.carry_in  (carry),
		.result    (alu_result),
		.carry_out (alu_carry),
		.zero      (alu_zero),
		.negative  (alu_negative)
	);

	reg_file u_reg_file (
		.phi0         (phi0),
		.rst          (rst),
		.src_reg      (src_reg),
		.dst_reg      (dst_reg),
		.wb_source    (wb_source),
		.reg_we       (reg_we),
		.flag_we      (flag_we),
		.carry_set    (carry_set),
		.carry_clear  (carry_clear),
		.alu_result   (alu_result),
		.alu_carry    (alu_carry),
		.alu_zero     (alu_zero),
		.alu_negative (alu_negative),
		.mem_data     (rdata),
		.a_out        (),
		.src_out      (wdata),
		.carry        (carry),
		.z_flag       (z_flag)
	);

endmodule

// File: sim/cpu_props.sv
module cpu_props import cpu_pkg::*; (
	input logic                  phi0,
	input logic                  rst,
	input logic [addr_width-1:0] addr,
	input logic                  r_w_n,
	input logic                  sync
);

	// Read by the testbench for its closing line
	int failures = 0;

	////////////////////////////////////////
	// Bus protocol
	////////////////////////////////////////

	// Opcode fetch is always a read
	no_write_on_sync: assert property (@(posedge phi0) disable iff (rst)
		!(sync && !r_w_n))
		else begin
			failures++;
			$error("sync and a write in the same cycle");
		end

	read_in_reset: assert property (@(posedge phi0)
		rst |-> r_w_n)
		else begin
			failures++;
			$error("r_w_n low while in reset");
		end

	// Stores are zero page only in this subset
	write_in_page_zero: assert property (@(posedge phi0) disable iff (rst)
		!r_w_n |-> (addr[addr_width-1:data_width] == '0))
		else begin
			failures++;
			$error("write outside page zero");
		end

	// Shortest instruction is two cycles
	no_back_to_back_sync: assert property (@(posedge phi0) disable iff (rst)
		sync |=> !sync)
		else begin
			failures++;
			$error("sync in two consecutive cycles");
		end

endmodule

// File: sim/cpu_checker.sv
module cpu_checker import cpu_pkg::*; #(
	parameter logic [addr_width-1:0] end_addr = 16'h00FF
) (
	input  logic                  phi0,
	input  logic                  rst,
	input  logic [addr_width-1:0] addr,
	input  logic [data_width-1:0] rdata,
	input  logic [data_width-1:0] wdata,
	input  logic                  r_w_n,
	input  logic                  sync,
	output logic                  done
);

	int value_errors = 0;
	int timing_errors = 0;

	logic [addr_width-1:0] exp_addr [$];
	logic [data_width-1:0] exp_data [$];
	string                 exp_name [$];

	logic                  started;
	logic                  have_prev;
	logic [data_width-1:0] prev_op;
	logic [addr_width-1:0] prev_addr;
	int                    gap;

	// Cycles from one sync to the next, per opcode
	function automatic int spacing_rule(input logic [data_width-1:0] op,
			input logic [addr_width-1:0] fetch_addr, input logic [addr_width-1:0] next_addr);
		case (op)
			op_lda_zp, op_sta_zp, op_stx_zp, op_sty_zp, op_jmp_abs: spacing_rule = 3;
			// Falling through means not taken
			op_beq, op_bne: spacing_rule = (next_addr == fetch_addr + 16'd2) ? 2 : 3;
			default: spacing_rule = 2;
		endcase
	endfunction

	task automatic expect_write(input logic [addr_width-1:0] a, input logic [data_width-1:0] d,
			input string name);
		exp_addr.push_back(a);
		exp_data.push_back(d);
		exp_name.push_back(name);
	endtask

	task automatic final_check();
		if (exp_addr.size() != 0) begin
			value_errors = value_errors + 1;
			$display("%0d expected writes never happened, the first one is %s",
				exp_addr.size(), exp_name[0]);
		end
	endtask

	////////////////////////////////////////
	// Bus writes in program order
	////////////////////////////////////////

	always @(posedge phi0) begin
		logic [addr_width-1:0] want_addr;
		logic [data_width-1:0] want_data;
		string                 want_name;
		if (rst) begin
			done <= 1'b0;
		end else if (!r_w_n) begin
			if (exp_addr.size() == 0) begin
				value_errors = value_errors + 1;
				$display("unexpected write of %h to %h after the last expected write", wdata, addr);
			end else begin
				want_addr = exp_addr.pop_front();
				want_data = exp_data.pop_front();
				want_name = exp_name.pop_front();
				if (addr !== want_addr || wdata !== want_data) begin
					value_errors = value_errors + 1;
					$display("[ERROR] %s: expected %h at %h, actual %h at %h",
						want_name, want_data, want_addr, wdata, addr);
				end
			end
			if (addr == end_addr) begin
				done <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Sync spacing
	////////////////////////////////////////

	always @(posedge phi0) begin
		if (rst) begin
			started   <= 1'b0;
			have_prev <= 1'b0;
			gap       <= 0;
		end else begin
			started <= 1'b1;
			if (!started && !(sync === 1'b1 && addr === reset_pc)) begin
				timing_errors = timing_errors + 1;
				$display("first cycle after reset is not an opcode fetch at %h", reset_pc);
			end
			if (sync) begin
				if (have_prev && gap != spacing_rule(prev_op, prev_addr, addr)) begin
					timing_errors = timing_errors + 1;
					$display("[ERROR] sync_spacing op %h at %h: expected %0d, actual %0d",
						prev_op, prev_addr, spacing_rule(prev_op, prev_addr, addr), gap);
				end
				have_prev <= 1'b1;
				prev_op   <= rdata;
				prev_addr <= addr;
				gap       <= 1;
			end else begin
				gap <= gap + 1;
			end
		end
	end

endmodule

// File: sim/tb_cpu.sv
module tb_cpu import cpu_pkg::*; ();

	localparam int unsigned seed     = 85;
	localparam int          n_rows   = 16;
	localparam logic [7:0]  end_slot = 8'hFF;
	localparam logic [7:0]  row_base = 8'h30;

	logic                  phi0;
	logic                  rst;
	logic [data_width-1:0] rdata;
	logic [data_width-1:0] wdata;
	logic [addr_width-1:0] addr;
	logic                  r_w_n;
	logic                  sync;
	logic                  done;

	logic [7:0]  mem [0:65535];
	logic [15:0] pc_emit;
	int          budget = 0;
	int          cycle_count = 0;
	int          other_errors = 0;
	int unsigned rng_seed;
	int unsigned discard;

	// Stimulus table
	logic [7:0] t_op [n_rows];
	logic [7:0] t_a [n_rows];
	logic [7:0] t_b [n_rows];
	logic       t_c [n_rows];
	string      t_name [n_rows];

	cpu_top u_cpu_top (
		.phi0  (phi0),
		.rst   (rst),
		.rdata (rdata),
		.addr  (addr),
		.wdata (wdata),
		.r_w_n (r_w_n),
		.sync  (sync)
	);

	cpu_checker #(.end_addr({8'h00, end_slot})) u_checker (
		.phi0  (phi0),
		.rst   (rst),
		.addr  (addr),
		.rdata (rdata),
		.wdata (wdata),
		.r_w_n (r_w_n),
		.sync  (sync),
		.done  (done)
	);

	bind cpu_top cpu_props u_props (
		.phi0  (phi0),
		.rst   (rst),
		.addr  (addr),
		.r_w_n (r_w_n),
		.sync  (sync)
	);

	initial begin
		phi0 = 1'b0;
		forever #2 phi0 = ~phi0;
	end

	// Memory with a combinational read port
	assign rdata = mem[addr];

	always @(posedge phi0) begin
		if (!rst && !r_w_n) begin
			mem[addr] <= wdata;
		end
	end

	////////////////////////////////////////
	// Program assembly
	////////////////////////////////////////

	task automatic put_byte(input logic [7:0] b);
		mem[pc_emit] = b;
		pc_emit = pc_emit + 1'b1;
	endtask

	task automatic emit_implied(input logic [7:0] op);
		put_byte(op);
		budget += 2;
	endtask

	task automatic emit_imm(input logic [7:0] op, input logic [7:0] v);
		put_byte(op);
		put_byte(v);
		budget += 2;
	endtask

	// Counted at the taken length
	task automatic emit_branch(input logic [7:0] op, input logic [7:0] offset);
		put_byte(op);
		put_byte(offset);
		budget += 3;
	endtask

	task automatic emit_zp(input logic [7:0] op, input logic [7:0] slot);
		put_byte(op);
		put_byte(slot);
		budget += 3;
	endtask

	task automatic emit_store(input logic [7:0] op, input logic [7:0] slot,
			input logic [7:0] data, input string name);
		emit_zp(op, slot);
		u_checker.expect_write({8'h00, slot}, data, name);
	endtask

	task automatic emit_jmp(input logic [15:0] target);
		put_byte(op_jmp_abs);
		put_byte(target[7:0]);
		put_byte(target[15:8]);
		budget += 3;
	endtask

	// Expected {carry, result} of the immediate ALU instructions
	function automatic logic [8:0] alu_model(input logic [7:0] op, input logic [7:0] a,
			input logic [7:0] b, input logic cin);
		int ia;
		int ib;
		int total;
		ia = a;
		ib = b;
		case (op)
			op_adc_imm: begin
				total = ia + ib + (cin ? 1 : 0);
				alu_model = {total > 255, total[7:0]};
			end
			// Carry set means no borrow
			op_sbc_imm: begin
				total = ia - ib - (cin ? 0 : 1);
				alu_model = {total >= 0, total[7:0]};
			end
			op_and_imm: alu_model = {cin, a & b};
			op_ora_imm: alu_model = {cin, a | b};
			op_eor_imm: alu_model = {cin, a ^ b};
			default:    alu_model = {cin, a};
		endcase
	endfunction

	function automatic logic [7:0] rand_byte();
		rand_byte = $urandom % 256;
	endfunction

	task automatic set_row(input int i, input logic [7:0] op, input logic [7:0] a,
			input logic [7:0] b, input logic c, input string name);
		t_op[i]   = op;
		t_a[i]    = a;
		t_b[i]    = b;
		t_c[i]    = c;
		t_name[i] = name;
	endtask

	task automatic load_table();
		logic [7:0] op;
		set_row(0, op_adc_imm, 8'h10, 8'h20, 1'b0, "adc_basic");
		set_row(1, op_adc_imm, 8'h10, 8'h20, 1'b1, "adc_carry_in");
		set_row(2, op_adc_imm, 8'hF0, 8'h20, 1'b0, "adc_carry_out");
		set_row(3, op_adc_imm, 8'hFF, 8'h00, 1'b1, "adc_wrap_zero");
		set_row(4, op_sbc_imm, 8'h50, 8'h20, 1'b1, "sbc_basic");
		set_row(5, op_sbc_imm, 8'h20, 8'h50, 1'b1, "sbc_borrow_out");
		set_row(6, op_sbc_imm, 8'h50, 8'h50, 1'b0, "sbc_borrow_in");
		set_row(7, op_and_imm, 8'hF0, 8'h3C, 1'b1, "and_keeps_carry");
		set_row(8, op_ora_imm, 8'h0F, 8'h30, 1'b0, "ora_basic");
		set_row(9, op_eor_imm, 8'hFF, 8'h5A, 1'b1, "eor_invert");
		set_row(10, op_and_imm, 8'h00, 8'hFF, 1'b0, "and_zero");
		for (int i = 11; i < n_rows; i++) begin
			case (i % 5)
				0: op = op_adc_imm;
				1: op = op_sbc_imm;
				2: op = op_and_imm;
				3: op = op_ora_imm;
				default: op = op_eor_imm;
			endcase
			set_row(i, op, rand_byte(), rand_byte(), $urandom % 2, $sformatf("random_%0d", i));
		end
	endtask

	task automatic build_program();
		logic [7:0] xr;
		logic [7:0] yr;
		logic [7:0] ar;
		logic [8:0] r;
		logic [7:0] slot;
		pc_emit = reset_pc;
		// Index registers and transfers
		xr = 8'h7F;
		emit_imm(op_ldx_imm, xr);
		emit_implied(op_inx);
		xr = xr + 1'b1;
		emit_store(op_stx_zp, 8'h10, xr, "inx");
		emit_implied(op_dex);
		emit_implied(op_dex);
		xr = xr - 2'd2;
		emit_store(op_stx_zp, 8'h11, xr, "dex");
		yr = 8'hFF;
		emit_imm(op_ldy_imm, yr);
		emit_implied(op_iny);
		yr = yr + 1'b1;
		emit_store(op_sty_zp, 8'h12, yr, "iny_wrap");
		emit_implied(op_txa);
		ar = xr;
		emit_store(op_sta_zp, 8'h13, ar, "txa");
		ar = 8'hC3;
		emit_imm(op_lda_imm, ar);
		emit_implied(op_tax);
		xr = ar;
		emit_store(op_stx_zp, 8'h14, xr, "tax");
		emit_implied(op_dey);
		yr = yr - 1'b1;
		emit_store(op_sty_zp, 8'h15, yr, "dey_wrap");

		////////////////////////////////////////
		// Branches and jump
		////////////////////////////////////////
		emit_imm(op_lda_imm, 8'h00);
		emit_branch(op_beq, 8'd4);
		emit_imm(op_lda_imm, 8'hE1);
		emit_zp(op_sta_zp, 8'h20);
		emit_imm(op_lda_imm, 8'hB1);
		emit_store(op_sta_zp, 8'h21, 8'hB1, "beq_taken");
		emit_imm(op_lda_imm, 8'h33);
		emit_branch(op_beq, 8'd4);
		emit_imm(op_lda_imm, 8'hB2);
		emit_store(op_sta_zp, 8'h22, 8'hB2, "beq_not_taken");
		emit_imm(op_lda_imm, 8'h44);
		emit_branch(op_bne, 8'd4);
		emit_imm(op_lda_imm, 8'hE3);
		emit_zp(op_sta_zp, 8'h23);
		emit_imm(op_lda_imm, 8'hB3);
		emit_store(op_sta_zp, 8'h24, 8'hB3, "bne_taken");
		emit_imm(op_lda_imm, 8'h00);
		emit_branch(op_bne, 8'd4);
		emit_imm(op_lda_imm, 8'hB4);
		emit_store(op_sta_zp, 8'h25, 8'hB4, "bne_not_taken");
		// Jump over a store that must never happen
		emit_jmp(pc_emit + 16'd7);
		emit_imm(op_lda_imm, 8'hE5);
		emit_zp(op_sta_zp, 8'h26);
		emit_imm(op_lda_imm, 8'hB5);
		emit_store(op_sta_zp, 8'h27, 8'hB5, "jmp_skip");

		// One result slot and one carry slot per table row
		for (int i = 0; i < n_rows; i++) begin
			slot = row_base + 8'(2 * i);
			r = alu_model(t_op[i], t_a[i], t_b[i], t_c[i]);
			emit_implied(t_c[i] ? op_sec : op_clc);
			emit_imm(op_lda_imm, t_a[i]);
			emit_imm(t_op[i], t_b[i]);
			emit_store(op_sta_zp, slot, r[7:0], {t_name[i], "_result"});
			emit_imm(op_lda_imm, 8'h00);
			emit_imm(op_adc_imm, 8'h00);
			emit_store(op_sta_zp, slot + 1'b1, {7'b0, r[8]}, {t_name[i], "_carry"});
		end

		// End marker, then spin on a jump to itself
		emit_imm(op_lda_imm, 8'hA5);
		emit_store(op_sta_zp, end_slot, 8'hA5, "end_marker");
		emit_jmp(pc_emit);
	endtask

	task automatic fill_memory();
		for (int i = 0; i < 65536; i++) begin
			mem[i] = i[7:0] ^ i[15:8] ^ 8'h5C;
		end
	endtask

	task automatic finish_run();
		int total;
		total = u_checker.value_errors + u_checker.timing_errors + other_errors
			+ u_cpu_top.u_props.failures;
		$display("errors: value %0d, timing %0d, assertion %0d, other %0d",
			u_checker.value_errors, u_checker.timing_errors,
			u_cpu_top.u_props.failures, other_errors);
		if (total == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	////////////////////////////////////////
	// Run control
	////////////////////////////////////////

	always @(posedge phi0) begin
		if (!rst) begin
			cycle_count = cycle_count + 1;
			if (cycle_count >= budget + 50) begin
				other_errors = other_errors + 1;
				$display("program did not reach the end marker within %0d cycles", cycle_count);
				finish_run();
			end
		end
	end

	initial begin
		rst = 1'b1;
		rng_seed = seed;
		discard = $urandom(rng_seed);
		fill_memory();
		load_table();
		build_program();
		repeat (3) @(posedge phi0);
		rst <= 1'b0;
		while (!done) begin
			@(posedge phi0);
		end
		// A few more loops of the final jump for stray writes
		repeat (8) @(posedge phi0);
		u_checker.final_check();
		finish_run();
	end

endmodule

// File: build.f
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/fetcher.sv
verilog/decoder.sv
verilog/cpu_top.sv
sim/cpu_props.sv
sim/cpu_checker.sv
sim/tb_cpu.sv

// File: Bender.yml
package:
  name: cpu_subset_6502

sources:
  - verilog/cpu_pkg.sv
  - verilog/alu.sv
  - verilog/reg_file.sv
  - verilog/fetcher.sv
  - verilog/decoder.sv
  - verilog/cpu_top.sv
  - target: simulation
    files:
      - sim/cpu_props.sv
      - sim/cpu_checker.sv
      - sim/tb_cpu.sv
